/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // ************************************************************
  // Widths
  // ************************************************************

  localparam int tag_w      = 8;   // Physical register tag
  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;
  localparam int op_w       = 2;
  localparam int zimm_w     = 5;   // Immediate operand of csrrwi/csrrsi/csrrci

  // ************************************************************
  // CSR operations
  // ************************************************************

  // Encodings follow funct3[1:0] of the CSR instructions; 2'b00 is unused
  localparam logic [op_w-1:0] csr_op_rw = 2'b01;
  localparam logic [op_w-1:0] csr_op_rs = 2'b10;
  localparam logic [op_w-1:0] csr_op_rc = 2'b11;

  // ************************************************************
  // Machine CSR addresses
  // ************************************************************

  localparam logic [csr_addr_w-1:0] csr_mscratch = 12'h340;
  localparam logic [csr_addr_w-1:0] csr_mepc     = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause   = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mtval    = 12'h343;

  // ************************************************************
  // Source field
  // ************************************************************

  // The same 8 bits of a renamed CSR instruction carry either the physical
  // tag of rs1 (register form) or the zero-padded zimm (immediate form).
  // The imm flag that travels with it decides which reading applies.
  typedef union packed {
    logic [tag_w-1:0] tag;
    struct packed {
      logic [tag_w-zimm_w-1:0] pad;  // Always zero
      logic [zimm_w-1:0]       zimm;
    } imm;
  } csr_src_u;

endpackage

`default_nettype wire

/* logic/result_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Result broadcasts from the ALU, multiplier and load pipes
interface result_bus_if;

  logic                       alu_valid;
  logic [csr_pkg::tag_w-1:0]  alu_tag;
  logic [csr_pkg::xlen-1:0]   alu_data;

  logic                       mul_valid;
  logic [csr_pkg::tag_w-1:0]  mul_tag;
  logic [csr_pkg::xlen-1:0]   mul_data;

  logic                       mem_valid;
  logic [csr_pkg::tag_w-1:0]  mem_tag;
  logic [csr_pkg::xlen-1:0]   mem_data;

  modport source (
    output alu_valid, alu_tag, alu_data,
    output mul_valid, mul_tag, mul_data,
    output mem_valid, mem_tag, mem_data
  );

  modport listen (
    input alu_valid, alu_tag, alu_data,
    input mul_valid, mul_tag, mul_data,
    input mem_valid, mem_tag, mem_data
  );

endinterface

`default_nettype wire

/* logic/phys_value_file.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_value_file (
  input  logic                       clk,
  input  logic                       reset,
  result_bus_if.listen               bus,
  input  logic                       wb_valid,
  input  logic [csr_pkg::tag_w-1:0]  wb_tag,
  input  logic [csr_pkg::xlen-1:0]   wb_data,
  input  logic [csr_pkg::tag_w-1:0]  rd_tag,
  output logic [csr_pkg::xlen-1:0]   rd_data
);

  localparam int entries = 2 ** csr_pkg::tag_w;

  logic [csr_pkg::xlen-1:0] values [entries];

  // ************************************************************
  // Write ports
  // ************************************************************

  // Later statements win, so the CSR writeback takes a same-tag collision.
  // Broadcasts seen while in reset are dropped.
  always_ff @(posedge clk) begin
    if (!reset) begin
      if (bus.alu_valid) begin
        values[bus.alu_tag] <= bus.alu_data;
      end
      if (bus.mul_valid) begin
        values[bus.mul_tag] <= bus.mul_data;
      end
      if (bus.mem_valid) begin
        values[bus.mem_tag] <= bus.mem_data;
      end
      if (wb_valid) begin
        values[wb_tag] <= wb_data;  // CSR unit's own result
      end
    end
  end

  // ************************************************************
  // Read port
  // ************************************************************

  // Combinational, so a value broadcast on the wakeup edge is already here
  // by the time the woken operation sits in exec
  assign rd_data = values[rd_tag];

endmodule

`default_nettype wire

/* logic/csr_station.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_station #(
  parameter int depth = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           dispatch_valid,
  input  logic [csr_pkg::tag_w-1:0]      dispatch_rd,
  input  logic [csr_pkg::op_w-1:0]       dispatch_op,
  input  logic                           dispatch_imm,
  input  csr_pkg::csr_src_u              dispatch_src,
  input  logic                           dispatch_src_ready,
  input  logic [csr_pkg::csr_addr_w-1:0] dispatch_csr,
  output logic                           full,
  result_bus_if.listen                   bus,
  input  logic                           wb_valid,
  input  logic [csr_pkg::tag_w-1:0]      wb_tag,
  output logic                           issue_valid,
  output logic [csr_pkg::tag_w-1:0]      issue_rd,
  output logic [csr_pkg::op_w-1:0]       issue_op,
  output logic                           issue_imm,
  output csr_pkg::csr_src_u              issue_src,
  output logic [csr_pkg::csr_addr_w-1:0] issue_csr
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  // ************************************************************
  // Entry storage
  // ************************************************************

  logic [csr_pkg::tag_w-1:0]      q_rd  [depth];
  logic [csr_pkg::op_w-1:0]       q_op  [depth];
  logic                           q_imm [depth];
  csr_pkg::csr_src_u              q_src [depth];
  logic [csr_pkg::csr_addr_w-1:0] q_csr [depth];
  logic [depth-1:0]               q_ready;

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;

  logic in_ready;    // Incoming operation already has its operand
  logic head_ready;
  logic bypass;      // Empty station, ready dispatch goes straight to issue
  logic pop;
  logic push;

  // True when any broadcast this cycle carries the given tag
  function automatic logic woken(input logic [csr_pkg::tag_w-1:0] tag);
    return (bus.alu_valid && (bus.alu_tag == tag)) ||
           (bus.mul_valid && (bus.mul_tag == tag)) ||
           (bus.mem_valid && (bus.mem_tag == tag)) ||
           (wb_valid && (wb_tag == tag));
  endfunction

  // ************************************************************
  // Issue decision
  // ************************************************************

  // Only the oldest entry may leave, CSR side effects stay in order
  always_comb begin
    in_ready   = dispatch_imm || dispatch_src_ready || woken(dispatch_src.tag);
    head_ready = q_ready[head] || (!q_imm[head] && woken(q_src[head].tag));
    bypass     = dispatch_valid && (count == '0) && in_ready;
    pop        = (count != '0) && head_ready;
    push       = dispatch_valid && !full && !bypass;
  end

  assign full = (count == cnt_w'(depth));

  // ************************************************************
  // Queue control
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      q_ready     <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= bypass || pop;
      if (pop) begin
        head <= head + 1'b1;  // Wraps since depth is a power of two
      end
      if (push) begin
        tail <= tail + 1'b1;
      end
      count <= count + cnt_w'(push) - cnt_w'(pop);
      for (int i = 0; i < depth; i++) begin
        if (!q_imm[i] && woken(q_src[i].tag)) begin
          q_ready[i] <= 1'b1;
        end
      end
      if (push) begin
        q_ready[tail] <= in_ready;  // Overrides a stale wake of the free slot
      end
    end
  end

  // ************************************************************
  // Payload
  // ************************************************************

  always_ff @(posedge clk) begin
    if (push) begin
      q_rd[tail]  <= dispatch_rd;
      q_op[tail]  <= dispatch_op;
      q_imm[tail] <= dispatch_imm;
      q_src[tail] <= dispatch_src;
      q_csr[tail] <= dispatch_csr;
    end
    if (bypass) begin
      issue_rd  <= dispatch_rd;
      issue_op  <= dispatch_op;
      issue_imm <= dispatch_imm;
      issue_src <= dispatch_src;
      issue_csr <= dispatch_csr;
    end else if (pop) begin
      issue_rd  <= q_rd[head];
      issue_op  <= q_op[head];
      issue_imm <= q_imm[head];
      issue_src <= q_src[head];
      issue_csr <= q_csr[head];
    end
  end

endmodule

`default_nettype wire

/* logic/csr_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_exec (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           issue_valid,
  input  logic [csr_pkg::tag_w-1:0]      issue_rd,
  input  logic [csr_pkg::op_w-1:0]       issue_op,
  input  logic                           issue_imm,
  input  csr_pkg::csr_src_u              issue_src,
  input  logic [csr_pkg::csr_addr_w-1:0] issue_csr,
  output logic [csr_pkg::tag_w-1:0]      rd_tag,
  input  logic [csr_pkg::xlen-1:0]       rd_data,
  output logic                           wb_valid,
  output logic [csr_pkg::tag_w-1:0]      wb_tag,
  output logic [csr_pkg::xlen-1:0]       wb_data
);

  logic                           ex_valid;
  logic [csr_pkg::tag_w-1:0]      ex_rd;
  logic [csr_pkg::op_w-1:0]       ex_op;
  logic                           ex_imm;
  csr_pkg::csr_src_u              ex_src;
  logic [csr_pkg::csr_addr_w-1:0] ex_csr;

  logic [csr_pkg::xlen-1:0] mscratch;
  logic [csr_pkg::xlen-1:0] mepc;
  logic [csr_pkg::xlen-1:0] mcause;
  logic [csr_pkg::xlen-1:0] mtval;

  logic [csr_pkg::xlen-1:0] operand;
  logic [csr_pkg::xlen-1:0] old_value;
  logic [csr_pkg::xlen-1:0] new_value;
  logic                     mapped;

  // ************************************************************
  // Issue register
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      ex_rd  <= issue_rd;
      ex_op  <= issue_op;
      ex_imm <= issue_imm;
      ex_src <= issue_src;
      ex_csr <= issue_csr;
    end
  end

  // ************************************************************
  // Operand and CSR read
  // ************************************************************

  assign rd_tag = ex_src.tag;  // Ignored by the mux below for the immediate form

  always_comb begin
    operand = ex_imm ? csr_pkg::xlen'(ex_src.imm.zimm) : rd_data;
    mapped  = 1'b1;
    case (ex_csr)
      csr_pkg::csr_mscratch: old_value = mscratch;
      csr_pkg::csr_mepc:     old_value = mepc;
      csr_pkg::csr_mcause:   old_value = mcause;
      csr_pkg::csr_mtval:    old_value = mtval;
      default: begin
        old_value = '0;     // Unimplemented CSRs read as zero
        mapped    = 1'b0;
      end
    endcase
    case (ex_op)
      csr_pkg::csr_op_rw: new_value = operand;
      csr_pkg::csr_op_rs: new_value = old_value | operand;
      csr_pkg::csr_op_rc: new_value = old_value & ~operand;
      default:            new_value = old_value;
    endcase
  end

  // ************************************************************
  // CSR update
  // ************************************************************

  // Written at the end of the writeback cycle, so the next operation reads it
  always_ff @(posedge clk) begin
    if (reset) begin
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (ex_valid && mapped) begin
      case (ex_csr)
        csr_pkg::csr_mscratch: mscratch <= new_value;
        csr_pkg::csr_mepc:     mepc     <= new_value;
        csr_pkg::csr_mcause:   mcause   <= new_value;
        default:               mtval    <= new_value;
      endcase
    end
  end

  // The destination register gets the value the CSR held before the update
  assign wb_valid = ex_valid;
  assign wb_tag   = ex_rd;
  assign wb_data  = old_value;

endmodule

`default_nettype wire

/* logic/csr_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_top #(
  parameter int depth = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           dispatch_valid,
  input  logic [csr_pkg::tag_w-1:0]      dispatch_rd,
  input  logic [csr_pkg::op_w-1:0]       dispatch_op,
  input  logic                           dispatch_imm,
  input  csr_pkg::csr_src_u              dispatch_src,
  input  logic                           dispatch_src_ready,
  input  logic [csr_pkg::csr_addr_w-1:0] dispatch_csr,
  input  logic                           alu_valid,
  input  logic [csr_pkg::tag_w-1:0]      alu_tag,
  input  logic [csr_pkg::xlen-1:0]       alu_data,
  input  logic                           mul_valid,
  input  logic [csr_pkg::tag_w-1:0]      mul_tag,
  input  logic [csr_pkg::xlen-1:0]       mul_data,
  input  logic                           mem_valid,
  input  logic [csr_pkg::tag_w-1:0]      mem_tag,
  input  logic [csr_pkg::xlen-1:0]       mem_data,
  output logic                           full,
  output logic                           result_valid,
  output logic [csr_pkg::tag_w-1:0]      result_tag,
  output logic [csr_pkg::xlen-1:0]       result_data
);

  logic                           issue_valid;
  logic [csr_pkg::tag_w-1:0]      issue_rd;
  logic [csr_pkg::op_w-1:0]       issue_op;
  logic                           issue_imm;
  csr_pkg::csr_src_u              issue_src;
  logic [csr_pkg::csr_addr_w-1:0] issue_csr;
  logic [csr_pkg::tag_w-1:0]      rd_tag;
  logic [csr_pkg::xlen-1:0]       rd_data;
  logic                           wb_valid;
  logic [csr_pkg::tag_w-1:0]      wb_tag;
  logic [csr_pkg::xlen-1:0]       wb_data;

  result_bus_if bus ();

  assign bus.alu_valid = alu_valid;
  assign bus.alu_tag   = alu_tag;
  assign bus.alu_data  = alu_data;
  assign bus.mul_valid = mul_valid;
  assign bus.mul_tag   = mul_tag;
  assign bus.mul_data  = mul_data;
  assign bus.mem_valid = mem_valid;
  assign bus.mem_tag   = mem_tag;
  assign bus.mem_data  = mem_data;

  phys_value_file u_values (
    .clk, .reset, .bus(bus.listen), .wb_valid, .wb_tag, .wb_data, .rd_tag, .rd_data
  );

  csr_station #(.depth(depth)) u_station (
    .clk, .reset, .flush,
    .dispatch_valid, .dispatch_rd, .dispatch_op, .dispatch_imm,
    .dispatch_src, .dispatch_src_ready, .dispatch_csr,
    .full, .bus(bus.listen), .wb_valid, .wb_tag,
    .issue_valid, .issue_rd, .issue_op, .issue_imm, .issue_src, .issue_csr
  );

  csr_exec u_exec (
    .clk, .reset, .flush,
    .issue_valid, .issue_rd, .issue_op, .issue_imm, .issue_src, .issue_csr,
    .rd_tag, .rd_data, .wb_valid, .wb_tag, .wb_data
  );

  assign result_valid = wb_valid;
  assign result_tag   = wb_tag;
  assign result_data  = wb_data;

endmodule

`default_nettype wire

/* tests/csr_issue_props.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_props (
  input logic clk,
  input logic reset,
  input logic flush,
  input logic issue_valid,
  input logic occupied,
  input logic full,
  input logic dispatch_valid,
  input logic wb_valid
);

  // An issue needs a stored entry or a dispatch in the cycle before
  issue_from_entry: assert property (@(posedge clk) disable iff (reset)
    issue_valid |-> $past(occupied || dispatch_valid))
    else $error("issue_valid with an empty queue");

  no_dispatch_when_full: assert property (@(posedge clk) disable iff (reset)
    full |-> !dispatch_valid) else $error("dispatch into a full queue");

  wb_after_issue: assert property (@(posedge clk) disable iff (reset)
    issue_valid && !flush |=> wb_valid) else $error("issue without writeback");

  wb_needs_issue: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(issue_valid)) else $error("writeback without issue");

endmodule

bind csr_station csr_issue_props u_props (
  .clk, .reset, .flush, .issue_valid, .occupied(count != '0), .full, .dispatch_valid,
  .wb_valid
);

`default_nettype wire

/* tests/csr_issue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_issue_tb;

  localparam int depth       = 8;
  localparam int num_ops     = 400;
  localparam int cycle_limit = num_ops * 40;

  typedef struct packed {
    logic [csr_pkg::tag_w-1:0]      rd;
    logic [csr_pkg::op_w-1:0]       op;
    logic                           imm;
    csr_pkg::csr_src_u              src;
    logic [csr_pkg::csr_addr_w-1:0] csr;
    logic                           fast;  // Ready into an empty station
    int                             cyc;
  } op_t;

  logic clk, reset, flush, full, result_valid;
  logic dispatch_valid, dispatch_imm, dispatch_src_ready;
  logic [csr_pkg::tag_w-1:0] dispatch_rd, alu_tag, mul_tag, mem_tag, result_tag;
  logic [csr_pkg::op_w-1:0] dispatch_op;
  csr_pkg::csr_src_u dispatch_src;
  logic [csr_pkg::csr_addr_w-1:0] dispatch_csr;
  logic alu_valid, mul_valid, mem_valid;
  logic [csr_pkg::xlen-1:0] alu_data, mul_data, mem_data, result_data;

  integer seed = 32'h68e4caf6;
  int cyc = 0;
  int results = 0;
  bit ready [256];
  int refs [256];
  logic [csr_pkg::xlen-1:0] value [256];
  logic [csr_pkg::xlen-1:0] csrs [4];
  op_t pend [$];
  logic [csr_pkg::tag_w-1:0] waits [$];
  logic [csr_pkg::tag_w-1:0] next_rd = 8'd128;  // Destinations live in the upper half
  logic [csr_pkg::tag_w-1:0] fill_tag;
  bit fill_on = 0;

  csr_issue_top #(.depth(depth)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic bit is_pending_rd(input logic [csr_pkg::tag_w-1:0] t);
    foreach (pend[i]) if (pend[i].rd == t) return 1'b1;
    return 1'b0;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_tag(input logic [csr_pkg::tag_w-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "tag mismatch");
    end
  endtask

  task automatic check_data(input logic [csr_pkg::xlen-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_latency(input int got, exp);
    if (got != exp) begin
      $display("CHECK FAILED at %0t: latency %0d expected %0d", $time, got, exp);
      $display("** FAIL **");
      $fatal(1, "latency mismatch");
    end
  endtask

  // ************************************************************
  // Reference model
  // ************************************************************

  task automatic take_result(output logic [csr_pkg::tag_w-1:0] wt,
                             output logic [csr_pkg::xlen-1:0] wd);
    op_t o;
    logic [csr_pkg::xlen-1:0] operand, old, nv;
    int idx;
    bit mapped;
    if (pend.size() == 0) abort_run("A result appeared with no operation pending");
    o = pend.pop_front();
    idx = int'(o.csr) - 'h340;
    mapped = (idx >= 0) && (idx < 4);
    operand = o.imm ? 32'(o.src.imm.zimm) : value[o.src.tag];
    old = mapped ? csrs[idx] : '0;
    case (o.op)
      csr_pkg::csr_op_rw: nv = operand;
      csr_pkg::csr_op_rs: nv = old | operand;
      default:            nv = old & ~operand;
    endcase
    check_tag(result_tag, o.rd, "result tag out of dispatch order");
    check_data(result_data, old, "old CSR value");
    if (o.fast) check_latency(cyc - o.cyc, 2);
    if (mapped) csrs[idx] = nv;
    if (!o.imm) refs[o.src.tag]--;
    wt = o.rd;
    wd = old;
    results++;
  endtask

  // One clock: check and update the model at the falling edge, then drive
  task automatic step(input int disp_pct, input bit bcast_on, input bit do_flush);
    op_t o;
    logic [csr_pkg::tag_w-1:0] t, wt, bt [3];
    logic [csr_pkg::xlen-1:0] wd, bd [3];
    bit disp, src_rdy, wake_now, got, bv [3];
    @(negedge clk);
    cyc++;
    if (cyc > cycle_limit) abort_run("Timeout: the run did not finish in its cycle budget");
    got = result_valid;
    if (got) take_result(wt, wd);
    if (alu_valid) begin
      value[alu_tag] = alu_data;
      ready[alu_tag] = 1;
    end
    if (mul_valid) begin
      value[mul_tag] = mul_data;
      ready[mul_tag] = 1;
    end
    if (mem_valid) begin
      value[mem_tag] = mem_data;
      ready[mem_tag] = 1;
    end
    if (got) begin
      value[wt] = wd;  // CSR writeback wins a same-tag collision
      ready[wt] = 1;
    end
    if (flush) begin
      pend.delete();
      foreach (refs[i]) refs[i] = 0;
    end
    o = '0;
    src_rdy = 0;
    wake_now = 0;
    disp = !do_flush && (pend.size() < depth) && (rnd(100) < disp_pct);
    if (disp) begin
      o.rd = next_rd;
      next_rd = (next_rd == 8'd255) ? 8'd128 : next_rd + 8'd1;
      ready[o.rd] = 0;
      case (rnd(3))
        0: o.op = csr_pkg::csr_op_rw;
        1: o.op = csr_pkg::csr_op_rs;
        default: o.op = csr_pkg::csr_op_rc;
      endcase
      o.csr = (rnd(6) < 5) ? 12'h340 + 12'(rnd(4)) : 12'h7c0;
      t = 8'(rnd(256));
      if (fill_on) begin
        o.src.tag = fill_tag;
      end else if (rnd(3) == 0) begin
        o.imm = 1;
        o.src.imm.zimm = 5'(rnd(32));
      end else if (ready[t] && (t >= 128 || refs[t] > 0 || rnd(2) == 0)) begin
        o.src.tag = t;
        src_rdy = 1;
      end else if (t < 128) begin
        o.src.tag = t;
        ready[t] = 0;  // Tag freed and renamed again
        waits.push_back(t);
        wake_now = (rnd(4) == 0);
      end else if (is_pending_rd(t)) begin
        o.src.tag = t;  // Woken by the CSR unit's own writeback
      end else begin
        o.imm = 1;
        o.src.imm.zimm = 5'(rnd(32));
      end
      if (!o.imm) refs[o.src.tag]++;
      o.fast = (o.imm || src_rdy) && (pend.size() == 0);
      o.cyc = cyc + 1;
      pend.push_back(o);
    end
    for (int b = 0; b < 3; b++) begin
      bv[b] = 0;
      bt[b] = '0;
      bd[b] = $random(seed);
      if (bcast_on && rnd(3) == 0) begin
        if (waits.size() > 0 && rnd(2) == 0) begin
          int k;
          k = rnd(waits.size());
          t = waits[k];
          waits.delete(k);
        end else begin
          t = 8'(rnd(128));
        end
        bv[b] = !(ready[t] && refs[t] > 0);
        bt[b] = t;
      end
    end
    if (wake_now) begin
      bv[0] = 1;
      bt[0] = o.src.tag;
    end
    @(posedge clk);
    flush              <= do_flush;
    dispatch_valid     <= disp;
    dispatch_rd        <= o.rd;
    dispatch_op        <= o.op;
    dispatch_imm       <= o.imm;
    dispatch_src       <= o.src;
    dispatch_src_ready <= src_rdy;
    dispatch_csr       <= o.csr;
    alu_valid <= bv[0];
    alu_tag   <= bt[0];
    alu_data  <= bd[0];
    mul_valid <= bv[1];
    mul_tag   <= bt[1];
    mul_data  <= bd[1];
    mem_valid <= bv[2];
    mem_tag   <= bt[2];
    mem_data  <= bd[2];
  endtask

  task automatic drain();
    while (pend.size() > 0) step(0, 1, 0);
  endtask

  // Park entries behind one tag that nobody broadcasts
  task automatic fill_station(input int n);
    step(0, 0, 0);  // Broadcasts already on the bus land before the tag is picked
    fill_tag = 8'(rnd(128));
    ready[fill_tag] = 0;
    fill_on = 1;
    repeat (n) step(100, 0, 0);
    fill_on = 0;
    repeat (2) step(0, 0, 0);
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    reset = 1'b1;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_rd = '0;
    dispatch_op = '0;
    dispatch_imm = 1'b0;
    dispatch_src = '0;
    dispatch_src_ready = 1'b0;
    dispatch_csr = '0;
    {alu_valid, mul_valid, mem_valid} = '0;
    {alu_tag, mul_tag, mem_tag} = '0;
    {alu_data, mul_data, mem_data} = '0;
    foreach (csrs[i]) csrs[i] = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    while (results < 150) step(50, 1, rnd(64) == 0);
    drain();
    fill_station(depth);
    #1 check_flag(full, 1'b1, "full after filling the station");
    waits.push_back(fill_tag);
    drain();
    fill_station(depth / 2);
    step(0, 0, 1);
    repeat (3) step(0, 0, 0);
    while (results < num_ops) step(50, 1, rnd(64) == 0);
    drain();
    repeat (4) step(0, 1, 0);
    if (pend.size() == 0 && results >= num_ops) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Run ended with %0d results and %0d pending", results, pend.size());
      $display("** FAIL **");
      $fatal(1, "run ended early");
    end
  end

endmodule

`default_nettype wire

/* files.f */
logic/csr_pkg.sv
logic/result_bus_if.sv
logic/phys_value_file.sv
logic/csr_station.sv
logic/csr_exec.sv
logic/csr_issue_top.sv
tests/csr_issue_props.sv
tests/csr_issue_tb.sv
